//--- core_ex_pkg.sv
`default_nettype none

package core_ex_pkg;

  // *************************************************************************
  // widths and base types.
  // *************************************************************************
  localparam int unsigned EX_XLEN    = 32;  // datapath width.
  localparam int unsigned EX_OP_W    = 5;   // opcode width.
  localparam int unsigned EX_SHAMT_W = 5;   // shift amount, log2 of xlen.

  typedef logic [EX_XLEN-1:0]    ex_word_t;   // operand or result word.
  typedef logic [EX_OP_W-1:0]    ex_op_t;     // operation code.
  typedef logic [EX_SHAMT_W-1:0] ex_shamt_t;  // barrel shifter amount.

  // *************************************************************************
  // opcodes.
  // *************************************************************************
  // single-cycle ops keep bit 0 clear.
  // bit 4 picks the shift direction, bit 1 picks arithmetic shift.
  localparam ex_op_t OP_ADD   = 5'b00000;
  localparam ex_op_t OP_SUB   = 5'b00010;
  localparam ex_op_t OP_SLL   = 5'b00100;
  localparam ex_op_t OP_SRL   = 5'b10100;
  localparam ex_op_t OP_SRA   = 5'b10110;
  localparam ex_op_t OP_SLT   = 5'b01000;  // signed compare.
  localparam ex_op_t OP_SLTU  = 5'b01100;  // unsigned compare.
  localparam ex_op_t OP_XOR   = 5'b10000;
  localparam ex_op_t OP_OR    = 5'b11000;
  localparam ex_op_t OP_AND   = 5'b11100;
  localparam ex_op_t OP_PASS  = 5'b11110;  // forwards in1.

  // multiply/divide ops set bit 0.
  // bit 2 selects divide, bit 1 selects the upper word or remainder.
  localparam ex_op_t OP_MUL   = 5'b00001;  // low product word.
  localparam ex_op_t OP_MULHU = 5'b00011;  // high product word, unsigned.
  localparam ex_op_t OP_DIVU  = 5'b00101;
  localparam ex_op_t OP_REMU  = 5'b00111;

  // *************************************************************************
  // issue record, held only inside the issue queue.
  // *************************************************************************
  typedef struct packed {
    ex_op_t   op;   // 5 bits.
    ex_word_t in1;  // 32 bits.
    ex_word_t in2;  // 32 bits, 69 in total.
  } ex_issue_t;

  // *************************************************************************
  // queue sizes and credits.
  // *************************************************************************
  localparam int unsigned EX_ISSUE_DEPTH  = 4;  // also the upstream's credits.
  localparam int unsigned EX_RESULT_DEPTH = 4;
  localparam int unsigned EX_OUT_CREDITS  = 2;  // consumer buffer size.

  // output credit counter, must hold the full count.
  localparam int unsigned EX_OUT_CNT_W = $clog2(EX_OUT_CREDITS + 1);
  typedef logic [EX_OUT_CNT_W-1:0] ex_ocnt_t;

  // *************************************************************************
  // multiply/divide sequencing.
  // *************************************************************************
  localparam int unsigned EX_MULDIV_STEPS = 32;  // one result bit per step.
  localparam int unsigned EX_STEP_CNT_W   = $clog2(EX_MULDIV_STEPS);
  typedef logic [EX_STEP_CNT_W-1:0] ex_step_t;

endpackage

`default_nettype wire

//--- core_ex_credit_fifo.sv
`timescale 1ns/100ps
`default_nettype none

// circular buffer shared by the issue queue and the result queue.
module core_ex_credit_fifo #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned depth     = 4
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;  // pointer width.
  localparam int unsigned cnt_w = $clog2(depth + 1);  // count reaches depth.

  payload_t         mem [depth];  // storage, no reset.
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;  // occupancy.
  logic             do_push;
  logic             do_pop;

  // pointer advance with wrap for depths that are not a power of two.
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty   = (count == '0);
  assign full    = (count == cnt_w'(depth));
  assign do_push = push && !full;   // credits keep writers inside the limit.
  assign do_pop  = pop && !empty;

  assign pop_data = mem[rd_ptr];  // head is visible right after the push edge.

  // *************************************************************************
  // storage write.
  // *************************************************************************
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // *************************************************************************
  // pointers and occupancy.
  // *************************************************************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;  // push only.
        2'b01:   count <= count - 1'b1;  // pop only.
        default: count <= count;         // both or neither.
      endcase
    end
  end

endmodule

`default_nettype wire

//--- core_ex_alu_shift.sv
`timescale 1ns/100ps
`default_nettype none

// five-level logarithmic barrel shifter.
module core_ex_alu_shift (
  input  logic                   lr,         // 0 left, 1 right.
  input  logic                   la,         // 0 logical, 1 arithmetic.
  input  core_ex_pkg::ex_word_t  in1,
  input  core_ex_pkg::ex_shamt_t shfit_bit,
  output core_ex_pkg::ex_word_t  out
);

  import core_ex_pkg::*;

  logic     fill;                     // bit shifted in from the top.
  ex_word_t stage [0:EX_SHAMT_W];     // one word per level.

  // sign fill only for arithmetic right shifts.
  assign fill     = lr & la & in1[EX_XLEN-1];
  assign stage[0] = in1;

  // *************************************************************************
  // level i shifts by 2**i when bit i of the amount is set.
  // *************************************************************************
  for (genvar i = 0; i < EX_SHAMT_W; i++) begin : g_level
    localparam int unsigned amt = 1 << i;

    assign stage[i+1] = !shfit_bit[i] ? stage[i] :                          // pass.
                        lr ? {{amt{fill}}, stage[i][EX_XLEN-1:amt]} :       // right.
                             {stage[i][EX_XLEN-1-amt:0], {amt{1'b0}}};      // left.
  end

  assign out = stage[EX_SHAMT_W];  // last level.

endmodule

`default_nettype wire

//--- core_ex_muldiv.sv
`timescale 1ns/100ps
`default_nettype none

// iterative unsigned multiply/divide.
// shift-add multiply and restoring divide share one accumulator.
module core_ex_muldiv (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  start,
  input  core_ex_pkg::ex_op_t   op,
  input  core_ex_pkg::ex_word_t in1,
  input  core_ex_pkg::ex_word_t in2,
  output logic                  done,
  output core_ex_pkg::ex_word_t result
);

  import core_ex_pkg::*;

  // *************************************************************************
  // state.
  // *************************************************************************
  logic             busy;       // iterations in progress.
  ex_step_t         step_cnt;   // current step.
  ex_op_t           op_q;       // latched op.
  ex_word_t         opa_q;      // dividend or multiplier.
  ex_word_t         opb_q;      // divisor or multiplicand.
  logic             div_zero;   // divisor was zero.
  logic [EX_XLEN:0] acc;        // high half, one spare bit for the carry.
  ex_word_t         sr;         // low half, quotient or product low.
  logic [EX_XLEN:0] acc_nxt;
  ex_word_t         sr_nxt;
  logic             load;
  logic             is_div;

  assign load   = start && !busy;
  assign is_div = op_q[2];      // divu and remu.

  // *************************************************************************
  // one iteration.
  // *************************************************************************
  always_comb begin : step_calc
    logic [EX_XLEN:0]   sum;      // multiply partial sum.
    logic [EX_XLEN:0]   shifted;  // remainder with the next dividend bit.
    logic [EX_XLEN+1:0] diff;     // trial subtract, top bit is the borrow.
    sum     = acc + {1'b0, opb_q};
    shifted = {acc[EX_XLEN-1:0], sr[EX_XLEN-1]};
    diff    = {1'b0, shifted} - {2'b00, opb_q};
    if (is_div) begin
      if (!diff[EX_XLEN+1]) begin
        acc_nxt = diff[EX_XLEN:0];           // divisor fits, keep the difference.
        sr_nxt  = {sr[EX_XLEN-2:0], 1'b1};
      end else begin
        acc_nxt = shifted;                   // restore.
        sr_nxt  = {sr[EX_XLEN-2:0], 1'b0};
      end
    end else begin
      if (sr[0]) begin
        acc_nxt = {1'b0, sum[EX_XLEN:1]};    // add then shift right.
        sr_nxt  = {sum[0], sr[EX_XLEN-1:1]};
      end else begin
        acc_nxt = {1'b0, acc[EX_XLEN:1]};    // shift only.
        sr_nxt  = {acc[0], sr[EX_XLEN-1:1]};
      end
    end
  end

  // *************************************************************************
  // sequencing.
  // *************************************************************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy     <= 1'b0;
      step_cnt <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;                          // single-cycle pulse.
      if (load) begin
        busy     <= 1'b1;
        step_cnt <= '0;
      end else if (busy) begin
        step_cnt <= step_cnt + 1'b1;
        if (step_cnt == ex_step_t'(EX_MULDIV_STEPS - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;                      // result valid in the next cycle.
        end
      end
    end
  end

  // operands and datapath.
  always_ff @(posedge clk) begin
    if (load) begin
      op_q     <= op;
      opa_q    <= in1;
      opb_q    <= in2;
      div_zero <= (in2 == '0);
      acc      <= '0;
      sr       <= in1;
    end else if (busy) begin
      acc <= acc_nxt;
      sr  <= sr_nxt;
    end
  end

  // *************************************************************************
  // result select, riscv defaults on a zero divisor.
  // *************************************************************************
  always_comb begin
    case (op_q)
      OP_MUL:   result = sr;
      OP_MULHU: result = acc[EX_XLEN-1:0];
      OP_DIVU:  result = div_zero ? '1 : sr;                   // quotient.
      OP_REMU:  result = div_zero ? opa_q : acc[EX_XLEN-1:0];  // remainder.
      default:  result = sr;
    endcase
  end

endmodule

`default_nettype wire

//--- core_ex_alu.sv
`timescale 1ns/100ps
`default_nettype none

// opcode decode and result select.
module core_ex_alu (
  input  logic                  clk,
  input  logic                  arst_n,
  input  core_ex_pkg::ex_op_t   op,
  input  logic                  op_wait_handle,  // head valid, result room.
  output logic                  op_ready,
  input  core_ex_pkg::ex_word_t in1,
  input  core_ex_pkg::ex_word_t in2,
  output core_ex_pkg::ex_word_t out
);

  import core_ex_pkg::*;

  // *************************************************************************
  // local signals.
  // *************************************************************************
  logic      shift_lr;
  logic      shift_la;
  ex_shamt_t shift_amt;
  ex_word_t  shift_out;
  logic      is_muldiv;
  logic      muldiv_start;
  logic      muldiv_busy;    // waiting for done.
  logic      muldiv_done;
  ex_word_t  muldiv_result;
  logic      slt_lt;
  logic      sltu_lt;

  // decode.
  assign shift_lr  = op[4];               // right when set.
  assign shift_la  = op[1];               // arithmetic when set.
  assign shift_amt = in2[EX_SHAMT_W-1:0];  // low bits only.
  assign is_muldiv = op[0];

  assign slt_lt  = $signed(in1) < $signed(in2);
  assign sltu_lt = in1 < in2;

  // one start per op, in the first cycle the head is offered.
  assign muldiv_start = op_wait_handle && is_muldiv && !muldiv_busy;
  assign op_ready     = is_muldiv ? muldiv_done : 1'b1;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      muldiv_busy <= 1'b0;
    end else if (muldiv_start) begin
      muldiv_busy <= 1'b1;
    end else if (muldiv_done) begin
      muldiv_busy <= 1'b0;  // head pops on this same edge.
    end
  end

  // *************************************************************************
  // result select.
  // *************************************************************************
  always_comb begin
    case (op)
      OP_ADD:   out = in1 + in2;
      OP_SUB:   out = in1 - in2;
      OP_SLL,
      OP_SRL,
      OP_SRA:   out = shift_out;
      OP_SLT:   out = {{(EX_XLEN-1){1'b0}}, slt_lt};
      OP_SLTU:  out = {{(EX_XLEN-1){1'b0}}, sltu_lt};
      OP_XOR:   out = in1 ^ in2;
      OP_OR:    out = in1 | in2;
      OP_AND:   out = in1 & in2;
      OP_MUL,
      OP_MULHU,
      OP_DIVU,
      OP_REMU:  out = muldiv_result;
      OP_PASS:  out = in1;
      default:  out = in1;  // undefined ops pass in1.
    endcase
  end

  // *************************************************************************
  // sub-units.
  // *************************************************************************
  core_ex_alu_shift core_ex_alu_shift_inst0 (
    .lr       (shift_lr ),
    .la       (shift_la ),
    .in1      (in1      ),
    .shfit_bit(shift_amt),
    .out      (shift_out)
  );

  core_ex_muldiv core_ex_muldiv_inst0 (
    .clk   (clk          ),
    .arst_n(arst_n       ),
    .start (muldiv_start ),
    .op    (op           ),
    .in1   (in1          ),
    .in2   (in2          ),
    .done  (muldiv_done  ),
    .result(muldiv_result)
  );

endmodule

`default_nettype wire

//--- core_ex.sv
`timescale 1ns/100ps
`default_nettype none

// execute stage top, credit flow control on both sides.
module core_ex (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  in_valid,    // one op per beat, credit held.
  input  core_ex_pkg::ex_op_t   in_op,
  input  core_ex_pkg::ex_word_t in_in1,
  input  core_ex_pkg::ex_word_t in_in2,
  output logic                  in_credit,   // one pulse per issue pop.
  output logic                  out_valid,   // one result per beat.
  output core_ex_pkg::ex_word_t out_data,
  input  logic                  out_credit   // consumer freed one slot.
);

  import core_ex_pkg::*;

  // *************************************************************************
  // local signals.
  // *************************************************************************
  ex_issue_t in_rec;       // packed upstream beat.
  ex_issue_t head;         // issue queue head.
  logic      issue_empty;
  logic      res_empty;
  logic      res_full;
  logic      op_wait_handle;
  logic      op_ready;
  logic      accept;       // head done this cycle.
  ex_word_t  alu_out;
  ex_ocnt_t  out_cnt;      // output credits held.

  assign in_rec.op  = in_op;
  assign in_rec.in1 = in_in1;
  assign in_rec.in2 = in_in2;

  // dispatch.
  assign op_wait_handle = !issue_empty && !res_full;
  assign accept         = op_wait_handle && op_ready;

  // output beat needs a result and a credit.
  assign out_valid = !res_empty && (out_cnt != '0);

  // *************************************************************************
  // credits.
  // *************************************************************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_credit <= 1'b0;
      out_cnt   <= ex_ocnt_t'(EX_OUT_CREDITS);
    end else begin
      in_credit <= accept;  // slot freed upstream.
      if (out_valid && !out_credit) begin
        out_cnt <= out_cnt - 1'b1;   // spent.
      end else if (!out_valid && out_credit) begin
        out_cnt <= out_cnt + 1'b1;   // returned.
      end
    end
  end

  // *************************************************************************
  // queues and alu.
  // *************************************************************************
  core_ex_credit_fifo #(
    .payload_t(ex_issue_t    ),
    .depth    (EX_ISSUE_DEPTH)
  ) issue_q (
    .clk      (clk        ),
    .arst_n   (arst_n     ),
    .push     (in_valid   ),
    .push_data(in_rec     ),
    .pop      (accept     ),
    .pop_data (head       ),
    .empty    (issue_empty),
    .full     (           )   // upstream credits bound the fill.
  );

  core_ex_alu core_ex_alu_inst0 (
    .clk           (clk           ),
    .arst_n        (arst_n        ),
    .op            (head.op       ),
    .op_wait_handle(op_wait_handle),
    .op_ready      (op_ready      ),
    .in1           (head.in1      ),
    .in2           (head.in2      ),
    .out           (alu_out       )
  );

  core_ex_credit_fifo #(
    .payload_t(ex_word_t      ),
    .depth    (EX_RESULT_DEPTH)
  ) result_q (
    .clk      (clk      ),
    .arst_n   (arst_n   ),
    .push     (accept   ),
    .push_data(alu_out  ),
    .pop      (out_valid),
    .pop_data (out_data ),
    .empty    (res_empty),
    .full     (res_full )
  );

endmodule

`default_nettype wire

//--- tb_core_ex.sv
`timescale 1ns/100ps
`default_nettype none

module tb_core_ex;

  import core_ex_pkg::*;

  localparam int N_VEC    = 33;    // table entries.
  localparam int BP_FIRST = 4;     // back-pressure run, first entry.
  localparam int BP_COUNT = 14;    // more than both queues and the consumer hold.
  localparam int TIMEOUT  = 2000;  // cycles allowed per wait.

  typedef struct packed {
    ex_op_t   op;
    ex_word_t in1;
    ex_word_t in2;
    ex_word_t exp;  // worked out by hand from the op rules.
  } vec_t;

  logic     clk;
  logic     arst_n;
  logic     in_valid;
  ex_op_t   in_op;
  ex_word_t in_in1;
  ex_word_t in_in2;
  logic     in_credit;
  logic     out_valid;
  ex_word_t out_data;
  logic     out_credit;

  vec_t tbl [0:N_VEC-1];
  int   n_loaded      = 0;
  int   issue_credits = EX_ISSUE_DEPTH;  // upstream view of free issue slots.
  int   in_credit_total = 0;
  int   beats         = 0;               // out_valid beats seen on the bus.
  int   owed          = 0;               // credits not yet returned.
  int   credit_delay  = 0;
  logic hold          = 1'b0;            // consumer withholds its credits.
  int   base_pulses;
  int   base_beats;

  core_ex UUT (
    .clk       (clk       ),
    .arst_n    (arst_n    ),
    .in_valid  (in_valid  ),
    .in_op     (in_op     ),
    .in_in1    (in_in1    ),
    .in_in2    (in_in2    ),
    .in_credit (in_credit ),
    .out_valid (out_valid ),
    .out_data  (out_data  ),
    .out_credit(out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period.
  end

  // *************************************************************************
  // failure reporting and compare tasks.
  // *************************************************************************
  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic stop_run(input string msg);
    $display("%s (at %0t ns)", msg, $time);
    abort_run();
  endtask

  task automatic check_result(input ex_word_t got, input ex_word_t exp, input int idx);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: entry %0d result %h, expected %h", $time, idx, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  // *************************************************************************
  // stimulus table.
  // *************************************************************************
  task automatic add_vec(input ex_op_t op, input ex_word_t a, input ex_word_t b,
                         input ex_word_t exp);
    vec_t v;
    v.op  = op;
    v.in1 = a;
    v.in2 = b;
    v.exp = exp;
    tbl[n_loaded] = v;
    n_loaded++;
  endtask

  task automatic load_table();
    add_vec(OP_ADD,   32'h0000_0005, 32'h0000_0007, 32'h0000_000c);
    add_vec(OP_MUL,   32'h0000_1234, 32'h0000_0010, 32'h0001_2340);
    add_vec(OP_ADD,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0000);  // wraps.
    add_vec(OP_SUB,   32'h0000_0003, 32'h0000_0005, 32'hffff_fffe);
    add_vec(OP_DIVU,  32'h0000_0064, 32'h0000_0007, 32'h0000_000e);  // 100 / 7.
    add_vec(OP_XOR,   32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0);
    add_vec(OP_OR,    32'h1234_0000, 32'h0000_5678, 32'h1234_5678);
    add_vec(OP_AND,   32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000);
    add_vec(OP_REMU,  32'h0000_0064, 32'h0000_0007, 32'h0000_0002);
    add_vec(OP_PASS,  32'hdead_beef, 32'h1234_5678, 32'hdead_beef);
    add_vec(OP_SLT,   32'hffff_fffe, 32'h0000_0001, 32'h0000_0001);  // -2 < 1.
    add_vec(OP_SLT,   32'h0000_0001, 32'hffff_fffe, 32'h0000_0000);
    add_vec(OP_SLTU,  32'hffff_fffe, 32'h0000_0001, 32'h0000_0000);
    add_vec(OP_SLTU,  32'h0000_0001, 32'hffff_fffe, 32'h0000_0001);
    add_vec(5'b01010, 32'hcafe_f00d, 32'h1111_1111, 32'hcafe_f00d);  // undefined op.
    add_vec(OP_MULHU, 32'h8000_0000, 32'h0000_0004, 32'h0000_0002);
    add_vec(OP_SLL,   32'h0000_0001, 32'h0000_0004, 32'h0000_0010);
    add_vec(OP_SLL,   32'h8000_0001, 32'h0000_0021, 32'h0000_0002);  // amount 1.
    add_vec(OP_SRL,   32'h8000_0000, 32'h0000_001f, 32'h0000_0001);
    add_vec(OP_SRA,   32'h8000_0000, 32'h0000_0004, 32'hf800_0000);
    add_vec(OP_SRA,   32'h7000_0000, 32'hffff_ffe4, 32'h0700_0000);  // amount 4.
    add_vec(OP_SRL,   32'hf000_000f, 32'h0000_0024, 32'h0f00_0000);
    add_vec(OP_SRA,   32'h8765_4321, 32'h0000_0008, 32'hff87_6543);
    add_vec(OP_MUL,   32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001);
    add_vec(OP_MULHU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
    add_vec(OP_DIVU,  32'h1234_5678, 32'h0000_0000, 32'hffff_ffff);  // divide by zero.
    add_vec(OP_REMU,  32'h1234_5678, 32'h0000_0000, 32'h1234_5678);
    add_vec(OP_DIVU,  32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001);
    add_vec(OP_REMU,  32'hffff_ffff, 32'h0000_0010, 32'h0000_000f);
    add_vec(OP_DIVU,  32'hffff_ffff, 32'h0000_0010, 32'h0fff_ffff);
    add_vec(OP_ADD,   32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000);
    add_vec(OP_SUB,   32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff);
    add_vec(OP_ADD,   32'h0000_0100, 32'hffff_ff00, 32'h0000_0000);
  endtask

  // *************************************************************************
  // upstream side, sends only while it holds a credit.
  // *************************************************************************
  task automatic run_issue(input int first, input int count);
    vec_t v;
    int   gap;
    int   cycles;
    for (int i = first; i < first + count; i++) begin
      v   = tbl[i];
      gap = $urandom % 3;  // idle cycles before this op.
      repeat (gap) begin
        @(posedge clk);
        #5;
      end
      cycles = 0;
      while (issue_credits == 0) begin
        @(posedge clk);
        #5;
        cycles++;
        if (cycles > TIMEOUT) stop_run("timed out waiting for an issue credit");
      end
      in_valid = 1'b1;
      in_op    = v.op;
      in_in1   = v.in1;
      in_in2   = v.in2;
      issue_credits--;  // spent on this beat.
      @(posedge clk);
      #5;
      in_valid = 1'b0;
      in_op    = '0;
      in_in1   = '0;
      in_in2   = '0;
    end
  endtask

  // result beats arrive in issue order, sampled mid cycle.
  task automatic collect(input int first, input int count);
    vec_t v;
    int   cycles;
    for (int i = first; i < first + count; i++) begin
      v      = tbl[i];
      cycles = 0;
      @(negedge clk);
      while (!out_valid) begin
        cycles++;
        if (cycles > TIMEOUT) stop_run("timed out waiting for a result beat");
        @(negedge clk);
      end
      check_result(out_data, v.exp, i);
      owed++;  // slot freed, credit goes back later.
    end
  endtask

  // both queues and the consumer fill, then everything must go quiet.
  task automatic watch_stall();
    int cycles;
    cycles = 0;
    while (in_credit_total - base_pulses < EX_OUT_CREDITS + EX_RESULT_DEPTH) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) stop_run("timed out waiting for the queues to fill");
    end
    repeat (20) @(negedge clk);
    check_count(beats - base_beats, EX_OUT_CREDITS, "beats with credits withheld");
    check_count(in_credit_total - base_pulses, EX_OUT_CREDITS + EX_RESULT_DEPTH,
                "in_credit pulses while stalled");
    hold = 1'b0;  // consumer starts returning credits.
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (owed != 0 || issue_credits != EX_ISSUE_DEPTH) begin
      @(posedge clk);
      #5;
      cycles++;
      if (cycles > TIMEOUT) stop_run("timed out waiting for credits to return");
    end
  endtask

  // *************************************************************************
  // monitors.
  // *************************************************************************
  initial begin
    forever begin
      @(negedge clk);
      if (arst_n && in_credit) begin
        issue_credits++;
        in_credit_total++;
      end
      if (arst_n && out_valid) begin
        beats++;  // every beat on the bus, expected or not.
      end
    end
  end

  // consumer credit return, one pulse per cycle at most.
  initial begin
    forever begin
      @(posedge clk);
      #5;
      out_credit = 1'b0;
      if (!hold && owed > 0) begin
        if (credit_delay == 0) begin
          out_credit   = 1'b1;
          owed--;
          credit_delay = $urandom % 4;
        end else begin
          credit_delay--;
        end
      end
    end
  end

  // *************************************************************************
  // main sequence.
  // *************************************************************************
  initial begin
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    in_op      = '0;
    in_in1     = '0;
    in_in2     = '0;
    out_credit = 1'b0;
    void'($urandom(32'h4f0b_cd67));  // single seed for the run.
    load_table();
    repeat (8) @(posedge clk);
    #5;
    arst_n = 1'b1;

    // quiet after reset.
    repeat (10) begin
      @(negedge clk);
      if (out_valid !== 1'b0 || in_credit !== 1'b0) begin
        stop_run("out_valid or in_credit went high with no stimulus applied");
      end
    end
    @(posedge clk);
    #5;

    // whole table, mixed single-cycle and multiply/divide ops.
    base_pulses = in_credit_total;
    fork
      run_issue(0, N_VEC);
      collect(0, N_VEC);
    join
    @(posedge clk);
    #5;
    wait_drain();
    check_count(in_credit_total - base_pulses, N_VEC, "in_credit pulses");
    check_count(beats, N_VEC, "result beats");

    // back-pressure, consumer holds its credits.
    hold        = 1'b1;
    base_pulses = in_credit_total;
    base_beats  = beats;
    fork
      run_issue(BP_FIRST, BP_COUNT);
      collect(BP_FIRST, BP_COUNT);
      watch_stall();
    join
    @(posedge clk);
    #5;
    wait_drain();
    check_count(in_credit_total - base_pulses, BP_COUNT, "in_credit pulses after stall");
    check_count(beats, N_VEC + BP_COUNT, "total result beats");

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- core_ex.f
core_ex_pkg.sv
core_ex_credit_fifo.sv
core_ex_alu_shift.sv
core_ex_muldiv.sv
core_ex_alu.sv
core_ex.sv
tb_core_ex.sv

//--- Bender.yml
package:
  name: core_ex

sources:
  - files:
      - core_ex_pkg.sv
      - core_ex_credit_fifo.sv
      - core_ex_alu_shift.sv
      - core_ex_muldiv.sv
      - core_ex_alu.sv
      - core_ex.sv

  - target: test
    files:
      - tb_core_ex.sv
